//--- flist.f
+incdir+logic
+incdir+test
logic/executePkg.sv
logic/stageIf.sv
logic/decodeStage.sv
logic/aluCore.sv
logic/executeStage.sv
logic/regFile.sv
logic/executeTop.sv
test/executeTb.sv

//--- Bender.yml
package:
  name: execute_slice

sources:
  - include_dirs:
      - logic
    files:
      - logic/executePkg.sv
      - logic/stageIf.sv
      - logic/decodeStage.sv
      - logic/aluCore.sv
      - logic/executeStage.sv
      - logic/regFile.sv
      - logic/executeTop.sv
  - target: test
    include_dirs:
      - logic
      - test
    files:
      - test/executeTb.sv

//--- test/executeVectors.svh
// columns: instruction word, expected wbEnable, wbReg, wbData, flags
// flags are {zero, negative, carry, overflow}; retireValid follows the valid bit
task automatic loadVectors;
    begin
        // immediates into fresh registers
        addRow(iTypeWord(6'h08, 0, 1, 16'h0F0F), 1'b1, 1, 32'h0000_0F0F, 4'b0000);  // addi
        addRow(iTypeWord(6'h0D, 0, 2, 16'hF00F), 1'b1, 2, 32'h0000_F00F, 4'b0000);  // ori, zext
        addRow(iTypeWord(6'h08, 0, 3, 16'hFFFF), 1'b1, 3, 32'hFFFF_FFFF, 4'b0100);  // addi -1
        addRow(iTypeWord(6'h0C, 1, 4, 16'h00FF), 1'b1, 4, 32'h0000_000F, 4'b0000);  // andi
        addRow(iTypeWord(6'h0E, 2, 5, 16'hFFFF), 1'b1, 5, 32'h0000_0FF0, 4'b0000);  // xori
        addRow(rTypeWord(1, 2, 6, 0, 6'h24), 1'b1, 6, 32'h0000_000F, 4'b0000);      // and
        addRow(rTypeWord(1, 2, 7, 0, 6'h25), 1'b1, 7, 32'h0000_FF0F, 4'b0000);      // or
        addRow(rTypeWord(1, 2, 8, 0, 6'h26), 1'b1, 8, 32'h0000_FF00, 4'b0000);      // xor
        addRow(rTypeWord(1, 2, 9, 0, 6'h27), 1'b1, 9, 32'hFFFF_00F0, 4'b0100);      // nor
        addRow(rTypeWord(4, 5, 10, 0, 6'h24), 1'b1, 10, 32'h0000_0000, 4'b1000);    // and -> 0
        // add/sub with carry and overflow
        addRow(iTypeWord(6'h09, 0, 11, 16'h0001), 1'b1, 11, 32'h0000_0001, 4'b0000); // addiu
        addRow(rTypeWord(0, 3, 12, 1, 6'h02), 1'b1, 12, 32'h7FFF_FFFF, 4'b0000);    // srl 1
        addRow(rTypeWord(3, 11, 13, 0, 6'h21), 1'b1, 13, 32'h0000_0000, 4'b1010);   // addu wrap
        addRow(rTypeWord(12, 11, 14, 0, 6'h20), 1'b0, 14, 32'h8000_0000, 4'b0101);  // add trap
        addRow(rTypeWord(11, 3, 15, 0, 6'h22), 1'b1, 15, 32'h0000_0002, 4'b0010);   // sub borrow
        addRow(rTypeWord(12, 3, 16, 0, 6'h22), 1'b0, 16, 32'h8000_0000, 4'b0111);   // sub trap
        addRow(rTypeWord(12, 3, 17, 0, 6'h23), 1'b1, 17, 32'h8000_0000, 4'b0111);   // subu
        addRow(rTypeWord(11, 11, 18, 0, 6'h23), 1'b1, 18, 32'h0000_0000, 4'b1000);  // subu -> 0
        // compares, mixed signs
        addRow(rTypeWord(3, 11, 19, 0, 6'h2A), 1'b1, 19, 32'h0000_0001, 4'b0000);   // slt
        addRow(rTypeWord(3, 11, 20, 0, 6'h2B), 1'b1, 20, 32'h0000_0000, 4'b1000);   // sltu
        addRow(iTypeWord(6'h0A, 11, 21, 16'hFFFF), 1'b1, 21, 32'h0000_0000, 4'b1000); // slti
        addRow(iTypeWord(6'h0A, 17, 22, 16'h0005), 1'b1, 22, 32'h0000_0001, 4'b0000); // slti
        // shifts by shamt, then by rs
        addRow(rTypeWord(0, 11, 23, 31, 6'h00), 1'b1, 23, 32'h8000_0000, 4'b0100);  // sll
        addRow(rTypeWord(0, 17, 24, 4, 6'h03), 1'b1, 24, 32'hF800_0000, 4'b0100);   // sra
        addRow(rTypeWord(0, 17, 25, 4, 6'h02), 1'b1, 25, 32'h0800_0000, 4'b0000);   // srl
        addRow(rTypeWord(15, 2, 26, 0, 6'h04), 1'b1, 26, 32'h0003_C03C, 4'b0000);   // sllv 2
        addRow(rTypeWord(15, 3, 27, 0, 6'h06), 1'b1, 27, 32'h3FFF_FFFF, 4'b0000);   // srlv 2
        addRow(rTypeWord(15, 17, 28, 0, 6'h07), 1'b1, 28, 32'hE000_0000, 4'b0100);  // srav 2
        addRow(rTypeWord(1, 9, 29, 0, 6'h07), 1'b1, 29, 32'hFFFF_FFFE, 4'b0100);    // srav 15
        // conditional moves, data is a either way
        addRow(rTypeWord(1, 11, 30, 0, 6'h0B), 1'b1, 30, 32'h0000_0F0F, 4'b0000);   // movn yes
        addRow(rTypeWord(2, 18, 31, 0, 6'h0B), 1'b0, 31, 32'h0000_F00F, 4'b0000);   // movn no
        addRow(rTypeWord(2, 18, 31, 0, 6'h0A), 1'b1, 31, 32'h0000_F00F, 4'b0000);   // movz yes
        addRow(rTypeWord(3, 11, 30, 0, 6'h0A), 1'b0, 30, 32'hFFFF_FFFF, 4'b0100);   // movz no
        // back-to-back dependencies
        addRow(iTypeWord(6'h09, 0, 5, 16'h0100), 1'b1, 5, 32'h0000_0100, 4'b0000);  // addiu
        addRow(rTypeWord(5, 5, 6, 0, 6'h21), 1'b1, 6, 32'h0000_0200, 4'b0000);      // dist 1
        addRow(rTypeWord(6, 5, 7, 0, 6'h21), 1'b1, 7, 32'h0000_0300, 4'b0000);      // dist 1+2
        addGap();
        addRow(rTypeWord(7, 6, 8, 0, 6'h23), 1'b1, 8, 32'h0000_0100, 4'b0000);      // over gap
        addRow(rTypeWord(30, 0, 9, 0, 6'h25), 1'b1, 9, 32'h0000_0F0F, 4'b0000);     // r30 kept
        // r0 and illegal encodings
        addRow(iTypeWord(6'h08, 11, 0, 16'h0005), 1'b0, 0, 32'h0000_0006, 4'b0000); // to r0
        addRow(rTypeWord(0, 11, 10, 0, 6'h21), 1'b1, 10, 32'h0000_0001, 4'b0000);   // r0 reads 0
        addRow(rTypeWord(1, 2, 12, 0, 6'h3F), 1'b0, 12, 32'h0000_0000, 4'b0000);    // bad funct
        addRow(iTypeWord(6'h3F, 1, 13, 16'h1234), 1'b0, 13, 32'h0000_0000, 4'b0000); // bad op
        addRow(rTypeWord(12, 0, 13, 0, 6'h21), 1'b1, 13, 32'h7FFF_FFFF, 4'b0000);   // r12 intact
    end
endtask

//--- test/executeTb.sv
`timescale 1ns/1ps
`include "execute_defs.svh"

module executeTb;

    // one table row, retireValid expected to equal valid
    typedef struct packed {
        logic                       valid;
        logic [`DATA_WIDTH-1:0]     instr;
        logic                       wb;
        logic [`REG_ADDR_WIDTH-1:0] dest;
        logic [`DATA_WIDTH-1:0]     data;
        logic [3:0]                 flags;  // zero negative carry overflow
    } vecRowT;

    logic                       clk;
    logic                       rstN;
    logic                       instrValid;
    logic [`DATA_WIDTH-1:0]     instr;
    logic                       retireValid;
    logic                       wbEnable;
    logic [`REG_ADDR_WIDTH-1:0] wbReg;
    logic [`DATA_WIDTH-1:0]     wbData;
    logic [3:0]                 flags;

    vecRowT vectors[$];
    int     cycleCount;
    int     cycleLimit;

    executeTop executeTop_inst (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .retireValid (retireValid),
        .wbEnable    (wbEnable),
        .wbReg       (wbReg),
        .wbData      (wbData),
        .flags       (flags)
    );

    always #20 clk = ~clk; // 40 ns period

    function automatic logic [31:0] rTypeWord(input int rs, input int rt, input int rd,
                                              input int shamt, input logic [5:0] funct);
        return {6'b000000, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct};
    endfunction

    function automatic logic [31:0] iTypeWord(input logic [5:0] op, input int rs, input int rt,
                                              input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    task automatic addRow(input logic [31:0] word, input logic wb, input int dest,
                          input logic [31:0] data, input logic [3:0] expFlags);
        vecRowT row;
        begin
            row.valid = 1'b1;
            row.instr = word;
            row.wb    = wb;
            row.dest  = dest[`REG_ADDR_WIDTH-1:0];
            row.data  = data;
            row.flags = expFlags;
            vectors.push_back(row);
        end
    endtask

    // bubble, nothing retires two cycles later
    task automatic addGap;
        begin
            vectors.push_back('0);
        end
    endtask

`include "executeVectors.svh"

    task automatic haltRun;
        begin
            $display("Something failed");
            $fatal(1, "simulation stopped on the first error");
        end
    endtask

    task automatic reportMismatch(input string field, input int idx, input logic [31:0] got,
                                  input logic [31:0] expected);
        begin
            $display("Mismatch at %0t: row %0d %s got %h expected %h",
                     $time, idx, field, got, expected);
            haltRun();
        end
    endtask

    task automatic checkRow(input vecRowT exp, input int idx);
        begin
            assert (retireValid === exp.valid)
                else reportMismatch("retireValid", idx, retireValid, exp.valid);
            assert (wbEnable === exp.wb)
                else reportMismatch("wbEnable", idx, wbEnable, exp.wb);
            if (exp.valid)  // payload is stale on a bubble
            begin
                assert (wbReg === exp.dest)
                    else reportMismatch("wbReg", idx, wbReg, exp.dest);
                assert (wbData === exp.data)
                    else reportMismatch("wbData", idx, wbData, exp.data);
                assert (flags === exp.flags)
                    else reportMismatch("flags", idx, flags, exp.flags);
            end
        end
    endtask

    // guard against a stuck run
    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount > cycleLimit)
        begin
            $display("Timeout: table not finished within %0d cycles", cycleLimit);
            haltRun();
        end
    end

    initial
    begin
        clk        = 1'b0;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        cycleCount = 0;
        loadVectors();
        cycleLimit = vectors.size() + 20;
        repeat (5) @(posedge clk); // reset over 5 cycles
        @(negedge clk);
        rstN = 1'b1;
        // row k driven here, row k-2 visible on the outputs now
        for (int k = 0; k < vectors.size() + 2; k++)
        begin
            if (k >= 2)
            begin
                checkRow(vectors[k-2], k - 2);
            end
            instrValid = (k < vectors.size()) ? vectors[k].valid : 1'b0;
            instr      = (k < vectors.size()) ? vectors[k].instr : '0;
            @(negedge clk);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

//--- logic/executeTop.sv
`timescale 1ns/1ps
`include "execute_defs.svh"

module executeTop import executePkg::*;
(
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       instrValid,
    input  logic [`DATA_WIDTH-1:0]     instr,
    output logic                       retireValid,  // 2 cycles after instrValid
    output logic                       wbEnable,
    output logic [`REG_ADDR_WIDTH-1:0] wbReg,
    output logic [`DATA_WIDTH-1:0]     wbData,
    output aluFlagsT                   flags
);
    logic [`REG_ADDR_WIDTH-1:0] rsAddr;
    logic [`REG_ADDR_WIDTH-1:0] rtAddr;
    logic [`DATA_WIDTH-1:0]     rsData;
    logic [`DATA_WIDTH-1:0]     rtData;
    logic                       fwdValid;
    logic [`REG_ADDR_WIDTH-1:0] fwdReg;
    logic [`DATA_WIDTH-1:0]     fwdData;

    decodeIf decBus ();
    resultIf resBus ();

    decodeStage decodeStage_inst (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),      // raw word into the union view
        .rsAddr     (rsAddr),
        .rtAddr     (rtAddr),
        .rsData     (rsData),
        .rtData     (rtData),
        .fwdValid   (fwdValid),
        .fwdReg     (fwdReg),
        .fwdData    (fwdData),
        .dec        (decBus)
    );

    executeStage executeStage_inst (
        .clk      (clk),
        .rstN     (rstN),
        .dec      (decBus),
        .res      (resBus),
        .fwdValid (fwdValid),
        .fwdReg   (fwdReg),
        .fwdData  (fwdData)
    );

    regFile regFile_inst (
        .clk    (clk),
        .rstN   (rstN),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .rsData (rsData),
        .rtData (rtData),
        .wr     (resBus)
    );

    // result register straight to the ports
    assign retireValid = resBus.retire;
    assign wbEnable    = resBus.writeEnable;
    assign wbReg       = resBus.dest;
    assign wbData      = resBus.data;
    assign flags       = resBus.flags;

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps
`include "execute_defs.svh"

module regFile
(
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [`REG_ADDR_WIDTH-1:0] rsAddr,
    input  logic [`REG_ADDR_WIDTH-1:0] rtAddr,
    output logic [`DATA_WIDTH-1:0]     rsData,
    output logic [`DATA_WIDTH-1:0]     rtData,
    resultIf.sink                      wr
);
    logic [`DATA_WIDTH-1:0] regs [1:`REG_COUNT-1]; // r0 has no storage
    logic                   rsHit;
    logic                   rtHit;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 1; i < `REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr.writeEnable && wr.dest != '0)
        begin
            regs[wr.dest] <= wr.data;
        end
    end

    // write-through covers the instruction two behind
    assign rsHit = wr.writeEnable && (wr.dest == rsAddr);
    assign rtHit = wr.writeEnable && (wr.dest == rtAddr);

    assign rsData = (rsAddr == '0) ? '0 : rsHit ? wr.data : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 : rtHit ? wr.data : regs[rtAddr];

    // execute must already have dropped r0 writes
    assert property (@(posedge clk) disable iff (!rstN) wr.writeEnable |-> wr.dest != '0);

endmodule

//--- logic/executeStage.sv
`timescale 1ns/1ps
`include "execute_defs.svh"

module executeStage import executePkg::*;
(
    input  logic                       clk,
    input  logic                       rstN,
    decodeIf.consumer                  dec,
    resultIf.producer                  res,
    output logic                       fwdValid,  // bypass to decode
    output logic [`REG_ADDR_WIDTH-1:0] fwdReg,
    output logic [`DATA_WIDTH-1:0]     fwdData
);
    logic [`DATA_WIDTH-1:0] aluResult;
    aluFlagsT               aluFlags;
    logic                   moveTaken;
    logic                   trapOvf;      // ADD/SUB/ADDI overflowed
    logic                   moveBlocked;  // MOVN/MOVZ condition false
    logic                   writeDecision;

    aluCore aluCore_inst (
        .op        (dec.op),
        .a         (dec.operandA),
        .b         (dec.operandB),
        .shamt     (dec.shamt),
        .result    (aluResult),
        .flags     (aluFlags),
        .moveTaken (moveTaken)
    );

    assign trapOvf     = (dec.op == aluAdd || dec.op == aluSub) && aluFlags.overflow;
    assign moveBlocked = (dec.op == aluMovn || dec.op == aluMovz) && !moveTaken;

    assign writeDecision = dec.valid && (dec.dest != '0) && (dec.op != aluIllegal) &&
                           !trapOvf && !moveBlocked;

    // live result for the younger instruction in decode
    assign fwdValid = writeDecision;
    assign fwdReg   = dec.dest;
    assign fwdData  = aluResult;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            res.retire      <= 1'b0;
            res.writeEnable <= 1'b0;
        end
        else
        begin
            res.retire      <= dec.valid;
            res.writeEnable <= writeDecision;
        end
    end

    always_ff @(posedge clk)
    begin
        res.dest  <= dec.dest;
        res.data  <= aluResult;
        res.flags <= aluFlags;
    end

    // a live decode register never carries unknown bits
    assert property (@(posedge clk) disable iff (!rstN)
        dec.valid |-> !$isunknown({dec.op, dec.dest, dec.operandA, dec.operandB, dec.shamt}));

endmodule

//--- logic/aluCore.sv
`timescale 1ns/1ps
`include "execute_defs.svh"

module aluCore import executePkg::*;
(
    input  aluOpT                   op,
    input  logic [`DATA_WIDTH-1:0]  a,          // rs
    input  logic [`DATA_WIDTH-1:0]  b,          // rt or immediate
    input  logic [`SHAMT_WIDTH-1:0] shamt,
    output logic [`DATA_WIDTH-1:0]  result,
    output aluFlagsT                flags,
    output logic                    moveTaken   // MOVN/MOVZ condition held
);
    localparam int Msb = `DATA_WIDTH - 1;

    logic [`DATA_WIDTH:0]    addWide;   // carry in top bit
    logic [`DATA_WIDTH:0]    subWide;   // borrow in top bit
    logic                    addOvf;
    logic                    subOvf;
    logic                    lessSigned;
    logic                    lessUnsigned;
    logic [`SHAMT_WIDTH-1:0] varShift;
    logic                    carryBit;
    logic                    ovfBit;

    assign addWide = {1'b0, a} + {1'b0, b};
    assign subWide = {1'b0, a} - {1'b0, b};

    // same-sign inputs, sign flipped in the sum
    assign addOvf = (a[Msb] == b[Msb]) && (addWide[Msb] != a[Msb]);
    // opposite signs, result sign differs from a
    assign subOvf = (a[Msb] != b[Msb]) && (subWide[Msb] != a[Msb]);

    assign lessSigned   = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;
    assign varShift     = a[`SHAMT_WIDTH-1:0]; // only low bits of rs count

    always_comb
    begin
        result    = '0;   // also the aluIllegal result
        carryBit  = 1'b0;
        ovfBit    = 1'b0;
        moveTaken = 1'b0;
        case (op)
            aluAdd, aluAddu:
            begin
                result   = addWide[Msb:0];
                carryBit = addWide[`DATA_WIDTH];
                ovfBit   = addOvf;
            end
            aluSub, aluSubu:
            begin
                result   = subWide[Msb:0];
                carryBit = subWide[`DATA_WIDTH];
                ovfBit   = subOvf;
            end
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluNor:  result = ~(a | b);
            aluSlt:  result = {{Msb{1'b0}}, lessSigned};    // 1 when a < b
            aluSltu: result = {{Msb{1'b0}}, lessUnsigned};
            aluSll:  result = b << shamt;
            aluSrl:  result = b >> shamt;
            aluSra:  result = $signed(b) >>> shamt;         // sign fill
            aluSllv: result = b << varShift;
            aluSrlv: result = b >> varShift;
            aluSrav: result = $signed(b) >>> varShift;
            aluMovn:
            begin
                result    = a;               // passed through either way
                moveTaken = (b != '0);
            end
            aluMovz:
            begin
                result    = a;
                moveTaken = (b == '0);
            end
            default: result = '0;
        endcase
    end

    // illegal op must not report zero
    assign flags = '{
        zero:     (op != aluIllegal) && (result == '0),
        negative: result[Msb],
        carry:    carryBit,
        overflow: ovfBit
    };

endmodule

//--- logic/decodeStage.sv
`timescale 1ns/1ps
`include "execute_defs.svh"

module decodeStage import executePkg::*;
(
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       instrValid,
    input  instrWordT                  instr,
    output logic [`REG_ADDR_WIDTH-1:0] rsAddr,
    output logic [`REG_ADDR_WIDTH-1:0] rtAddr,
    input  logic [`DATA_WIDTH-1:0]     rsData,
    input  logic [`DATA_WIDTH-1:0]     rtData,
    input  logic                       fwdValid,  // live write decision of execute
    input  logic [`REG_ADDR_WIDTH-1:0] fwdReg,
    input  logic [`DATA_WIDTH-1:0]     fwdData,
    decodeIf.producer                  dec
);
    logic                       isRType;
    logic                       immSigned;
    logic [`DATA_WIDTH-1:0]     immExt;
    logic [`DATA_WIDTH-1:0]     regA;       // rs after bypass
    logic [`DATA_WIDTH-1:0]     regB;       // rt after bypass
    aluOpT                      nextOp;
    logic [`REG_ADDR_WIDTH-1:0] nextDest;

    assign isRType = (instr.rType.op == opRType);
    assign rsAddr  = instr.rType.rs; // same bits in both views
    assign rtAddr  = instr.rType.rt;

    // sign extend only the arithmetic immediates
    assign immSigned = (instr.iType.op == opAddi) || (instr.iType.op == opAddiu) ||
                       (instr.iType.op == opSlti);
    assign immExt = immSigned ? {{(`DATA_WIDTH-16){instr.iType.imm16[15]}}, instr.iType.imm16}
                              : {{(`DATA_WIDTH-16){1'b0}}, instr.iType.imm16};

    // bypass wins over the array, N-2 comes via regfile write-through
    assign regA = (fwdValid && fwdReg == rsAddr) ? fwdData : rsData;
    assign regB = (fwdValid && fwdReg == rtAddr) ? fwdData : rtData;

    always_comb
    begin
        nextOp   = aluIllegal;
        nextDest = isRType ? instr.rType.rd : instr.iType.rt;
        if (isRType)
        begin
            case (instr.rType.funct)
                functAdd:  nextOp = aluAdd;
                functAddu: nextOp = aluAddu;
                functSub:  nextOp = aluSub;
                functSubu: nextOp = aluSubu;
                functAnd:  nextOp = aluAnd;
                functOr:   nextOp = aluOr;
                functXor:  nextOp = aluXor;
                functNor:  nextOp = aluNor;
                functSlt:  nextOp = aluSlt;
                functSltu: nextOp = aluSltu;
                functSll:  nextOp = aluSll;
                functSrl:  nextOp = aluSrl;
                functSra:  nextOp = aluSra;
                functSllv: nextOp = aluSllv;
                functSrlv: nextOp = aluSrlv;
                functSrav: nextOp = aluSrav;
                functMovn: nextOp = aluMovn;
                functMovz: nextOp = aluMovz;
                default:   nextOp = aluIllegal; // unknown funct
            endcase
        end
        else
        begin
            case (instr.iType.op)
                opAddi:  nextOp = aluAdd;   // traps like ADD
                opAddiu: nextOp = aluAddu;
                opSlti:  nextOp = aluSlt;
                opAndi:  nextOp = aluAnd;
                opOri:   nextOp = aluOr;
                opXori:  nextOp = aluXor;
                default: nextOp = aluIllegal;
            endcase
        end
    end

    // decode register, valid only is control
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            dec.valid <= 1'b0;
        end
        else
        begin
            dec.valid <= instrValid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (instrValid)
        begin
            dec.op       <= nextOp;
            dec.dest     <= nextDest;
            dec.operandA <= regA;
            dec.operandB <= isRType ? regB : immExt;
            dec.shamt    <= instr.rType.shamt;
        end
    end

    // the field decode above assumes a clean word
    assert property (@(posedge clk) disable iff (!rstN) instrValid |-> !$isunknown(instr));

endmodule

//--- logic/stageIf.sv
`timescale 1ns/1ps
`include "execute_defs.svh"

// decode register contents, decode -> execute
interface decodeIf import executePkg::*;;
    logic                       valid;
    aluOpT                      op;
    logic [`REG_ADDR_WIDTH-1:0] dest;      // rd or rt
    logic [`DATA_WIDTH-1:0]     operandA;  // rs, already forwarded
    logic [`DATA_WIDTH-1:0]     operandB;  // rt or extended imm16
    logic [`SHAMT_WIDTH-1:0]    shamt;

    modport producer (
        output valid, op, dest, operandA, operandB, shamt
    );

    modport consumer (
        input valid, op, dest, operandA, operandB, shamt
    );
endinterface

// result register contents, execute -> regfile and top ports
interface resultIf import executePkg::*;;
    logic                       retire;       // an instruction finished
    logic                       writeEnable;  // and it may write dest
    logic [`REG_ADDR_WIDTH-1:0] dest;
    logic [`DATA_WIDTH-1:0]     data;
    aluFlagsT                   flags;

    modport producer (
        output retire, writeEnable, dest, data, flags
    );

    // regfile write port, retire and flags not needed there
    modport sink (
        input writeEnable, dest, data
    );
endinterface

//--- logic/executePkg.sv
`include "execute_defs.svh"

package executePkg;

    // one instruction word, two field layouts
    typedef struct packed {
        logic [5:0]                 op;    // zero for R-type
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`SHAMT_WIDTH-1:0]    shamt;
        logic [5:0]                 funct;
    } rTypeT;

    typedef struct packed {
        logic [5:0]                 op;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;    // destination here
        logic [15:0]                imm16;
    } iTypeT;

    typedef union packed {
        rTypeT rType;
        iTypeT iType;
    } instrWordT;

    typedef enum logic [4:0] {
        aluAdd, aluAddu, aluSub, aluSubu,
        aluAnd, aluOr, aluXor, aluNor,
        aluSlt, aluSltu,
        aluSll, aluSrl, aluSra, aluSllv, aluSrlv, aluSrav,
        aluMovn, aluMovz,
        aluIllegal
    } aluOpT;

    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;     // borrow on subtract
        logic overflow;  // signed
    } aluFlagsT;

    // opcode field
    localparam logic [5:0] opRType = 6'b000000;
    localparam logic [5:0] opAddi  = 6'b001000;
    localparam logic [5:0] opAddiu = 6'b001001;
    localparam logic [5:0] opSlti  = 6'b001010;
    localparam logic [5:0] opAndi  = 6'b001100;
    localparam logic [5:0] opOri   = 6'b001101;
    localparam logic [5:0] opXori  = 6'b001110;

    // funct field, R-type only
    localparam logic [5:0] functSll  = 6'b000000;
    localparam logic [5:0] functSrl  = 6'b000010;
    localparam logic [5:0] functSra  = 6'b000011;
    localparam logic [5:0] functSllv = 6'b000100;
    localparam logic [5:0] functSrlv = 6'b000110;
    localparam logic [5:0] functSrav = 6'b000111;
    localparam logic [5:0] functMovz = 6'b001010;
    localparam logic [5:0] functMovn = 6'b001011;
    localparam logic [5:0] functAdd  = 6'b100000;
    localparam logic [5:0] functAddu = 6'b100001;
    localparam logic [5:0] functSub  = 6'b100010;
    localparam logic [5:0] functSubu = 6'b100011;
    localparam logic [5:0] functAnd  = 6'b100100;
    localparam logic [5:0] functOr   = 6'b100101;
    localparam logic [5:0] functXor  = 6'b100110;
    localparam logic [5:0] functNor  = 6'b100111;
    localparam logic [5:0] functSlt  = 6'b101010;
    localparam logic [5:0] functSltu = 6'b101011;

endpackage

//--- logic/execute_defs.svh
`ifndef EXECUTE_DEFS_SVH
`define EXECUTE_DEFS_SVH

// operand, result and forwarding width
`define DATA_WIDTH 32

// register file shape
`define REG_COUNT 32
`define REG_ADDR_WIDTH 5 // enough for REG_COUNT entries

// shamt field, also the variable shift amount
`define SHAMT_WIDTH 5

`endif
